//--- verilog/periph_pkg.sv
// Shared widths, address map and address layout of the peripheral block.
// Windows are 4 KiB and selected by address bits [15:12]. Bits [31:16] are
// ignored, so the map repeats every 64 KiB. Only word accesses are supported.

package periph_pkg;

    localparam int DataWidth  = 32;
    localparam int AddrWidth  = 32;

    // Window numbers, also the bit positions in the one-hot select
    localparam int WinTimer   = 0;
    localparam int WinGpio    = 1;
    localparam int NumTargets = 2;

    localparam logic [DataWidth-1:0] ErrData = 32'hDEADBEEF;

    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    // One address word, seen raw or split into its decoded fields
    typedef union packed {
        logic [AddrWidth-1:0] raw;
        struct packed {
            logic [AddrWidth-17:0] unused_hi;  // [31:16]
            logic [3:0]            window;     // [15:12]
            logic [5:0]            unused_mid; // [11:6]
            logic [3:0]            reg_idx;    // [5:2]
            logic [1:0]            byte_off;   // [1:0]
        } f;
    } periph_addr_u;

endpackage

//--- verilog/periph_bus_if.sv
// Register bus from the decoder to one peripheral window.
// req_valid is a single-cycle strobe. rdata is combinational from req_addr
// and is sampled by the response stage in the request cycle.

`timescale 1ns/1ps

interface periph_bus_if;
    import periph_pkg::*;

    logic                 req_valid;
    logic                 req_write;
    periph_addr_u         req_addr;
    logic [DataWidth-1:0] req_wdata;
    logic [DataWidth-1:0] rdata;

    modport decoder (
        output req_valid, req_write, req_addr, req_wdata
    );

    modport target (
        input  req_valid, req_write, req_addr, req_wdata,
        output rdata
    );

    // Response stage only picks up the read data
    modport observer (
        input rdata
    );

endinterface

//--- verilog/periph_axil_decode.sv
// AXI4-Lite front end and window decoder.
// One transaction at a time; AW and W must be presented together.
// A write has priority over a read offered in the same cycle.
// No write strobes, every write is a full word.

`timescale 1ns/1ps

module periph_axil_decode (
    input  logic                              clk_i,
    input  logic                              rst_i,
    // AXI4-Lite request channels
    input  logic                              aw_valid_i,
    output logic                              aw_ready_o,
    input  logic [periph_pkg::AddrWidth-1:0]  aw_addr_i,
    input  logic                              w_valid_i,
    output logic                              w_ready_o,
    input  logic [periph_pkg::DataWidth-1:0]  w_data_i,
    input  logic                              ar_valid_i,
    output logic                              ar_ready_o,
    input  logic [periph_pkg::AddrWidth-1:0]  ar_addr_i,
    // Towards the response stage
    output logic                              issue_o,
    output logic                              issue_write_o,
    output logic [periph_pkg::NumTargets-1:0] issue_sel_o,
    input  logic                              busy_i,
    // Targets
    periph_bus_if.decoder                     timer_bus,
    periph_bus_if.decoder                     gpio_bus
);
    import periph_pkg::*;

    logic                  wr_accept;
    logic                  rd_accept;
    logic                  accept;
    logic                  issue_q;
    logic                  write_q;
    periph_addr_u          addr_q;
    logic [DataWidth-1:0]  wdata_q;
    logic [NumTargets-1:0] sel;

    // ----------------------------------------
    // Acceptance
    // ----------------------------------------
    assign wr_accept  = aw_valid_i & w_valid_i & ~busy_i;
    assign rd_accept  = ar_valid_i & ~wr_accept & ~busy_i;
    assign accept     = wr_accept | rd_accept;

    assign aw_ready_o = wr_accept;
    assign w_ready_o  = wr_accept;
    assign ar_ready_o = rd_accept;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= accept; // Strobe for exactly one cycle
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            addr_q.raw <= aw_addr_i;
            wdata_q    <= w_data_i;
            write_q    <= 1'b1;
        end else if (rd_accept) begin
            addr_q.raw <= ar_addr_i;
            write_q    <= 1'b0;
        end
    end

    // ----------------------------------------
    // Window decode
    // ----------------------------------------
    always_comb begin
        sel = '0;
        if (addr_q.f.window == 4'(WinTimer)) sel[WinTimer] = 1'b1;
        if (addr_q.f.window == 4'(WinGpio))  sel[WinGpio]  = 1'b1;
    end

    assign issue_o       = issue_q;
    assign issue_write_o = write_q;
    assign issue_sel_o   = sel; // All zero for an unmapped window

    assign timer_bus.req_valid = issue_q & sel[WinTimer];
    assign timer_bus.req_write = write_q;
    assign timer_bus.req_addr  = addr_q;
    assign timer_bus.req_wdata = wdata_q;

    assign gpio_bus.req_valid  = issue_q & sel[WinGpio];
    assign gpio_bus.req_write  = write_q;
    assign gpio_bus.req_addr   = addr_q;
    assign gpio_bus.req_wdata  = wdata_q;

    // Response stage must report busy right after any handshake
    a_one_in_flight: assert property (@(posedge clk_i) disable iff (rst_i)
        accept |=> (busy_i && !accept));

endmodule

//--- verilog/periph_timer.sv
// Timer register block with NumTimers 32-bit up counters.
// Timer i owns register indices 4i..4i+3: ctrl, count, compare, status.
// The 4-bit register index limits NumTimers to at most 4.
// Status bit 0 is the pending flag, cleared by writing 1.

`timescale 1ns/1ps

module periph_timer #(
    parameter int NumTimers = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    periph_bus_if.target         bus,
    output logic [NumTimers-1:0] irq_o
);
    import periph_pkg::*;

    logic [3:0]                          idx;
    logic                                wr;
    logic [NumTimers-1:0]                en_q;
    logic [NumTimers-1:0]                pend_q;
    logic [NumTimers-1:0][DataWidth-1:0] count_q;
    logic [NumTimers-1:0][DataWidth-1:0] cmp_q;

    assign idx = bus.req_addr.f.reg_idx;
    assign wr  = bus.req_valid & bus.req_write;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q    <= '0;
            pend_q  <= '0;
            count_q <= '0;
            cmp_q   <= '0;
        end else begin
            for (int i = 0; i < NumTimers; i++) begin
                if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                    if (count_q[i] == cmp_q[i]) pend_q[i] <= 1'b1;
                end
                // Bus writes override counting on the same edge
                if (wr && idx[3:2] == 2'(i)) begin
                    case (idx[1:0])
                        2'd0: en_q[i]    <= bus.req_wdata[0];
                        2'd1: count_q[i] <= bus.req_wdata;
                        2'd2: cmp_q[i]   <= bus.req_wdata;
                        default: begin
                            if (bus.req_wdata[0]) pend_q[i] <= 1'b0; // W1C
                        end
                    endcase
                end
            end
        end
    end

    // Read shows register state before a write in the same cycle
    always_comb begin
        bus.rdata = '0;
        for (int i = 0; i < NumTimers; i++) begin
            if (idx[3:2] == 2'(i)) begin
                case (idx[1:0])
                    2'd0:    bus.rdata = {{(DataWidth-1){1'b0}}, en_q[i]};
                    2'd1:    bus.rdata = count_q[i];
                    2'd2:    bus.rdata = cmp_q[i];
                    default: bus.rdata = {{(DataWidth-1){1'b0}}, pend_q[i]};
                endcase
            end
        end
    end

    assign irq_o = pend_q;

    for (genvar g = 0; g < NumTimers; g++) begin : gen_chk
        a_pend_needs_en: assert property (@(posedge clk_i) disable iff (rst_i)
            $rose(pend_q[g]) |-> $past(en_q[g]));
    end

endmodule

//--- verilog/periph_gpio.sv
// GPIO registers. Index 0 drives the LEDs, index 1 reads the DIP switches.
// Switch inputs are assumed synchronous to clk_i.

`timescale 1ns/1ps

module periph_gpio (
    input  logic         clk_i,
    input  logic         rst_i,
    periph_bus_if.target bus,
    output logic [7:0]   leds_o,
    input  logic [7:0]   dip_switches_i
);
    import periph_pkg::*;

    logic [7:0] leds_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            leds_q <= '0;
        end else if (bus.req_valid && bus.req_write && bus.req_addr.f.reg_idx == 4'd0) begin
            leds_q <= bus.req_wdata[7:0];
        end
    end

    always_comb begin
        case (bus.req_addr.f.reg_idx)
            4'd0:    bus.rdata = {{(DataWidth-8){1'b0}}, leds_q};
            4'd1:    bus.rdata = {{(DataWidth-8){1'b0}}, dip_switches_i}; // Read only
            default: bus.rdata = '0;
        endcase
    end

    assign leds_o = leds_q;

endmodule

//--- verilog/periph_resp_mux.sv
// Response stage and error slave for unmapped windows.
// Registers B or R one cycle after issue and holds it until the handshake.
// busy_o covers the whole span from issue to the response handshake.

`timescale 1ns/1ps

module periph_resp_mux (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              issue_i,
    input  logic                              issue_write_i,
    input  logic [periph_pkg::NumTargets-1:0] issue_sel_i,
    periph_bus_if.observer                    timer_bus,
    periph_bus_if.observer                    gpio_bus,
    // AXI4-Lite response channels
    output logic                              b_valid_o,
    output logic [1:0]                        b_resp_o,
    input  logic                              b_ready_i,
    output logic                              r_valid_o,
    output logic [periph_pkg::DataWidth-1:0]  r_data_o,
    output logic [1:0]                        r_resp_o,
    input  logic                              r_ready_i,
    output logic                              busy_o
);
    import periph_pkg::*;

    logic [DataWidth-1:0] rd_data;
    logic [1:0]           resp;
    logic                 b_valid_q;
    logic                 r_valid_q;
    logic [1:0]           b_resp_q;
    logic [1:0]           r_resp_q;
    logic [DataWidth-1:0] r_data_q;

    always_comb begin
        rd_data = ErrData;
        resp    = RespSlvErr; // Unmapped unless a target is selected
        if (issue_sel_i[WinTimer]) begin
            rd_data = timer_bus.rdata;
            resp    = RespOkay;
        end else if (issue_sel_i[WinGpio]) begin
            rd_data = gpio_bus.rdata;
            resp    = RespOkay;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (b_valid_q && b_ready_i) b_valid_q <= 1'b0;
            if (r_valid_q && r_ready_i) r_valid_q <= 1'b0;
            if (issue_i) begin
                if (issue_write_i) b_valid_q <= 1'b1;
                else               r_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i && issue_write_i) begin
            b_resp_q <= resp;
        end else if (issue_i) begin
            r_resp_q <= resp;
            r_data_q <= rd_data;
        end
    end

    assign b_valid_o = b_valid_q;
    assign b_resp_o  = b_resp_q;
    assign r_valid_o = r_valid_q;
    assign r_data_o  = r_data_q;
    assign r_resp_o  = r_resp_q;
    assign busy_o    = issue_i | b_valid_q | r_valid_q;

    // Decoder must not issue while a read response is stalled
    a_r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_data_o)));

endmodule

//--- verilog/periph_top.sv
// Peripheral block on a single 32-bit AXI4-Lite slave port.
// Window 0 timers, window 1 GPIO, windows 2..15 answer SLVERR/0xDEADBEEF.
// No write strobes, IDs or bursts. One transaction in flight.
// Response appears two cycles after the address handshake.

`timescale 1ns/1ps

module periph_top #(
    parameter int NumTimers = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    // AXI4-Lite slave
    input  logic                             aw_valid_i,
    output logic                             aw_ready_o,
    input  logic [periph_pkg::AddrWidth-1:0] aw_addr_i,
    input  logic                             w_valid_i,
    output logic                             w_ready_o,
    input  logic [periph_pkg::DataWidth-1:0] w_data_i,
    output logic                             b_valid_o,
    input  logic                             b_ready_i,
    output logic [1:0]                       b_resp_o,
    input  logic                             ar_valid_i,
    output logic                             ar_ready_o,
    input  logic [periph_pkg::AddrWidth-1:0] ar_addr_i,
    output logic                             r_valid_o,
    input  logic                             r_ready_i,
    output logic [periph_pkg::DataWidth-1:0] r_data_o,
    output logic [1:0]                       r_resp_o,
    // Pins
    output logic [7:0]                       leds_o,
    input  logic [7:0]                       dip_switches_i,
    output logic [NumTimers-1:0]             irq_o
);
    import periph_pkg::*;

    logic                  issue;
    logic                  issue_write;
    logic [NumTargets-1:0] issue_sel;
    logic                  busy;

    periph_bus_if timer_bus ();
    periph_bus_if gpio_bus ();

    periph_axil_decode i_decode (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .aw_valid_i    ( aw_valid_i  ),
        .aw_ready_o    ( aw_ready_o  ),
        .aw_addr_i     ( aw_addr_i   ),
        .w_valid_i     ( w_valid_i   ),
        .w_ready_o     ( w_ready_o   ),
        .w_data_i      ( w_data_i    ),
        .ar_valid_i    ( ar_valid_i  ),
        .ar_ready_o    ( ar_ready_o  ),
        .ar_addr_i     ( ar_addr_i   ),
        .issue_o       ( issue       ),
        .issue_write_o ( issue_write ),
        .issue_sel_o   ( issue_sel   ),
        .busy_i        ( busy        ),
        .timer_bus     ( timer_bus   ),
        .gpio_bus      ( gpio_bus    )
    );

    periph_timer #(
        .NumTimers ( NumTimers )
    ) i_timer (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .bus   ( timer_bus ),
        .irq_o ( irq_o     )
    );

    periph_gpio i_gpio (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .bus            ( gpio_bus       ),
        .leds_o         ( leds_o         ),
        .dip_switches_i ( dip_switches_i )
    );

    periph_resp_mux i_resp (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .issue_i       ( issue       ),
        .issue_write_i ( issue_write ),
        .issue_sel_i   ( issue_sel   ),
        .timer_bus     ( timer_bus   ),
        .gpio_bus      ( gpio_bus    ),
        .b_valid_o     ( b_valid_o   ),
        .b_resp_o      ( b_resp_o    ),
        .b_ready_i     ( b_ready_i   ),
        .r_valid_o     ( r_valid_o   ),
        .r_data_o      ( r_data_o    ),
        .r_resp_o      ( r_resp_o    ),
        .r_ready_i     ( r_ready_i   ),
        .busy_o        ( busy        )
    );

endmodule

//--- test/tb_periph.sv
// Random-stimulus testbench for periph_top with a small register model.
// LCG stimulus with a fixed seed. Stops at the first mismatch.
// Assumes NumTimers = 2 and the timer window at address 0.

`timescale 1ns/1ps

module tb_periph;
    import periph_pkg::*;

    localparam int NumTimers = 2;
    localparam int Timeout   = 100; // Cycles per wait loop
    localparam logic [AddrWidth-1:0] GpioBase = 32'h0000_1000;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
    logic [AddrWidth-1:0] aw_addr_i, ar_addr_i;
    logic [DataWidth-1:0] w_data_i, r_data_o;
    logic                 b_valid_o, b_ready_i, ar_valid_i, ar_ready_o;
    logic                 r_valid_o, r_ready_i;
    logic [1:0]           b_resp_o, r_resp_o;
    logic [7:0]           leds_o, dip_switches_i;
    logic [NumTimers-1:0] irq_o;

    // Register model
    logic [7:0]           led_model;
    logic [DataWidth-1:0] cmp_model [NumTimers];
    logic                 ctrl_model [NumTimers];
    logic                 pend_model [NumTimers];

    logic [31:0] rng_state = 32'd47200;

    periph_top #(.NumTimers(NumTimers)) DUT (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]}; // Weak low bits moved up
    endfunction

    function automatic logic [AddrWidth-1:0] timer_addr(input int t, input int r);
        return AddrWidth'((4 * t + r) * 4);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_data(input logic [DataWidth-1:0] got,
                              input logic [DataWidth-1:0] exp, input string what);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp,
                              input string what);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0d ns: %s response is %0d, expected %0d",
                               $time, what, got, exp));
    endtask

    // ----------------------------------------
    // Bus handshakes
    // ----------------------------------------
    task automatic wait_accept(input bit is_write, input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!(is_write ? (aw_ready_o && w_ready_o) : ar_ready_o)) begin
            if (n == Timeout) fail_run({"Timeout waiting for the ", what, " to be accepted"});
            n++;
            @(negedge clk_i);
        end
    endtask

    // Called on the handshake edge. Response is due two cycles later
    task automatic wait_response(input bit is_write, input string what);
        int n;
        n = 1;
        @(negedge clk_i);
        while (!(is_write ? b_valid_o : r_valid_o)) begin
            if (n == Timeout) fail_run({"Timeout waiting for the ", what, " response"});
            n++;
            @(negedge clk_i);
        end
        if (n != 2)
            fail_run($sformatf("[ERROR] %0d ns: %s response came %0d cycles after handshake",
                               $time, what, n));
    endtask

    // Holds ready low and offers a competing LED write plus a read meanwhile
    task automatic stall_response(input int cycles, input bit is_write,
                                  input logic [DataWidth-1:0] data, input logic [1:0] resp);
        repeat (cycles) begin
            @(posedge clk_i);
            aw_valid_i <= 1'b1;
            aw_addr_i  <= GpioBase;
            w_valid_i  <= 1'b1;
            w_data_i   <= lcg_next();
            ar_valid_i <= 1'b1;
            ar_addr_i  <= GpioBase;
            @(negedge clk_i);
            if (aw_ready_o || w_ready_o || ar_ready_o)
                fail_run("A new request was accepted while a response was pending");
            if (is_write) begin
                if (!b_valid_o) fail_run("bvalid dropped while bready was low");
                check_resp(b_resp_o, resp, "stalled write");
            end else begin
                if (!r_valid_o) fail_run("rvalid dropped while rready was low");
                check_data(r_data_o, data, "stalled rdata");
                check_resp(r_resp_o, resp, "stalled read");
            end
        end
        @(posedge clk_i);
        aw_valid_i <= 1'b0;
        w_valid_i  <= 1'b0;
        ar_valid_i <= 1'b0;
    endtask

    task automatic axil_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                              input int stall, output logic [1:0] resp);
        @(posedge clk_i);
        aw_valid_i <= 1'b1;
        aw_addr_i  <= addr;
        w_valid_i  <= 1'b1;
        w_data_i   <= data;
        wait_accept(1'b1, "write");
        @(posedge clk_i);
        aw_valid_i <= 1'b0;
        w_valid_i  <= 1'b0;
        wait_response(1'b1, "write");
        resp = b_resp_o;
        stall_response(stall, 1'b1, '0, resp);
        b_ready_i <= 1'b1;
        @(posedge clk_i);
        b_ready_i <= 1'b0;
    endtask

    task automatic axil_read(input logic [AddrWidth-1:0] addr, input int stall,
                             output logic [DataWidth-1:0] data, output logic [1:0] resp);
        @(posedge clk_i);
        ar_valid_i <= 1'b1;
        ar_addr_i  <= addr;
        wait_accept(1'b0, "read");
        @(posedge clk_i);
        ar_valid_i <= 1'b0;
        wait_response(1'b0, "read");
        data = r_data_o;
        resp = r_resp_o;
        stall_response(stall, 1'b0, data, resp);
        r_ready_i <= 1'b1;
        @(posedge clk_i);
        r_ready_i <= 1'b0;
    endtask

    task automatic write_check(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                               input int stall, input logic [1:0] exp_resp, input string what);
        logic [1:0] resp;
        axil_write(addr, data, stall, resp);
        check_resp(resp, exp_resp, what);
    endtask

    task automatic read_check(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] exp,
                              input int stall, input logic [1:0] exp_resp, input string what);
        logic [DataWidth-1:0] data;
        logic [1:0]           resp;
        axil_read(addr, stall, data, resp);
        check_data(data, exp, what);
        check_resp(resp, exp_resp, what);
    endtask

    task automatic wait_irq(input int t);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!irq_o[t]) begin
            if (n == Timeout) fail_run($sformatf("Timeout waiting for irq_o[%0d]", t));
            n++;
            @(negedge clk_i);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [DataWidth-1:0] v;
        logic [AddrWidth-1:0] a;
        int                   r;
        rst_i          = 1'b1;
        aw_valid_i     = 1'b0;
        aw_addr_i      = '0;
        w_valid_i      = 1'b0;
        w_data_i       = '0;
        b_ready_i      = 1'b0;
        ar_valid_i     = 1'b0;
        ar_addr_i      = '0;
        r_ready_i      = 1'b0;
        dip_switches_i = '0;
        led_model      = '0;
        for (int t = 0; t < NumTimers; t++) begin
            cmp_model[t]  = '0;
            ctrl_model[t] = 1'b0;
            pend_model[t] = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);

        if (b_valid_o || r_valid_o) fail_run("A response valid is high after reset");
        check_data(DataWidth'(leds_o), '0, "leds_o after reset");
        check_data(DataWidth'(irq_o), '0, "irq_o after reset");
        for (int t = 0; t < NumTimers; t++) begin
            read_check(timer_addr(t, 2), cmp_model[t], 0, RespOkay, "reset compare");
            read_check(timer_addr(t, 0), DataWidth'(ctrl_model[t]), 0, RespOkay, "reset ctrl");
        end

        // GPIO
        repeat (8) begin
            v = lcg_next();
            write_check(GpioBase, v, 0, RespOkay, "LED write");
            led_model = v[7:0];
            @(negedge clk_i);
            check_data(DataWidth'(leds_o), DataWidth'(led_model), "leds_o");
            read_check(GpioBase, DataWidth'(led_model), 0, RespOkay, "LED readback");
            v = lcg_next();
            dip_switches_i <= v[7:0];
            read_check(GpioBase + 4, DataWidth'(v[7:0]), 0, RespOkay, "DIP switches");
        end

        // Timer registers
        for (int t = 0; t < NumTimers; t++) begin
            v = lcg_next();
            write_check(timer_addr(t, 2), v, 0, RespOkay, "compare write");
            cmp_model[t] = v;
        end
        for (int t = 0; t < NumTimers; t++)
            read_check(timer_addr(t, 2), cmp_model[t], 0, RespOkay, "compare readback");
        repeat (4) begin
            r = 4 * NumTimers + int'(lcg_next() % (16 - 4 * NumTimers));
            read_check(AddrWidth'(r * 4), '0, 0, RespOkay, "unused timer index");
        end

        // Timer interrupts
        for (int t = 0; t < NumTimers; t++) begin
            v = 5 + lcg_next() % 20;
            write_check(timer_addr(t, 1), '0, 0, RespOkay, "count write");
            write_check(timer_addr(t, 2), v, 0, RespOkay, "compare write");
            cmp_model[t] = v;
            write_check(timer_addr(t, 0), 1, 0, RespOkay, "enable");
            ctrl_model[t] = 1'b1;
            wait_irq(t);
            pend_model[t] = 1'b1;
            read_check(timer_addr(t, 3), DataWidth'(pend_model[t]), 0, RespOkay, "pending");
            write_check(timer_addr(t, 0), '0, 0, RespOkay, "disable");
            ctrl_model[t] = 1'b0;
            write_check(timer_addr(t, 3), 1, 0, RespOkay, "status clear");
            pend_model[t] = 1'b0;
            @(negedge clk_i);
            check_data(DataWidth'(irq_o[t]), '0, "irq after clear");
            read_check(timer_addr(t, 3), DataWidth'(pend_model[t]), 0, RespOkay, "cleared");
            read_check(timer_addr(t, 0), DataWidth'(ctrl_model[t]), 0, RespOkay, "ctrl");
        end

        // Unmapped windows 2..15
        repeat (6) begin
            r = 2 + int'(lcg_next() % 14);
            a = lcg_next();
            a[15:12] = 4'(r);
            a[5:2]   = r[0] ? 4'd2 : 4'd0; // LED or compare index if misrouted
            a[1:0]   = 2'b00;
            read_check(a, ErrData, 0, RespSlvErr, "unmapped read");
            write_check(a, lcg_next(), 0, RespSlvErr, "unmapped write");
            read_check(GpioBase, DataWidth'(led_model), 0, RespOkay, "LED after unmapped");
            read_check(timer_addr(0, 2), cmp_model[0], 0, RespOkay, "compare after unmapped");
        end

        // Back-pressure with competing requests held during the stall
        repeat (4) begin
            v = lcg_next();
            write_check(GpioBase, v, 1 + int'(lcg_next() % 6), RespOkay, "stalled LED write");
            led_model = v[7:0];
            read_check(GpioBase, DataWidth'(led_model), 1 + int'(lcg_next() % 6), RespOkay,
                       "stalled LED read");
            read_check(32'h0000_5000, ErrData, 1 + int'(lcg_next() % 6), RespSlvErr,
                       "stalled unmapped read");
        end
        read_check(GpioBase, DataWidth'(led_model), 0, RespOkay, "final LED readback");

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tb.f
verilog/periph_pkg.sv
verilog/periph_bus_if.sv
verilog/periph_axil_decode.sv
verilog/periph_timer.sv
verilog/periph_gpio.sv
verilog/periph_resp_mux.sv
verilog/periph_top.sv
test/tb_periph.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph -f tb.f \
    || { echo "Build failed"; exit 1; }
out="$(./obj_dir/Vtb_periph 2>&1)"
echo "$out"
echo "$out" | grep -q "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
